/* verilog/shift_pkg.sv */
package shift_pkg;

    // Datapath width and binary shift amount width.
    localparam int DATA_W  = 8;
    localparam int SHAMT_W = 3;

    // Cycles from request strobe to response strobe.
    localparam int LATENCY = 2;

    typedef enum logic [2:0] {
        SHL = 3'd0,
        SHR = 3'd1,
        ASR = 3'd2,
        ROL = 3'd3,
        ROR = 3'd4
    } shift_op_e;

    // Request as presented at the top level.
    typedef struct packed {
        shift_op_e          op;
        logic [SHAMT_W-1:0] amount;
        logic [DATA_W-1:0]  data;
    } shift_req_t;

    // Request after decode, amount replaced by a one-hot lane.
    typedef struct packed {
        shift_op_e         op;
        logic [DATA_W-1:0] lane;
        logic [DATA_W-1:0] data;
    } shift_dec_t;

    typedef struct packed {
        logic [DATA_W-1:0] result;
        logic              carry;
        logic              zero;
    } shift_rsp_t;

endpackage

/* verilog/onehot_decoder.sv */
`timescale 1ns/1ps

module onehot_decoder (
    input  logic                          clk,
    input  logic [shift_pkg::SHAMT_W-1:0] amount,
    output logic [shift_pkg::DATA_W-1:0]  lane
);

    import shift_pkg::*;

    // One comparator per lane.
    for (genvar i = 0; i < DATA_W; i++) begin : g_lane
        assign lane[i] = (amount == SHAMT_W'(i));
    end

    // Amount must always hit exactly one lane, so the width pair stays consistent.
    a_lane_onehot: assert property (
        @(posedge clk) $onehot(lane)
    ) else $error("lane select not one-hot: %h", lane);

endmodule

/* verilog/onehot_mux.sv */
`timescale 1ns/1ps

module onehot_mux #(
    parameter int N        = 8,
    parameter int DATA_W_P = 8
) (
    input  logic                  clk,
    input  logic                  valid,
    input  logic [N*DATA_W_P-1:0] in,
    input  logic [N-1:0]          sel,
    output logic [DATA_W_P-1:0]   out
);

    // AND each slice with its select, then OR all slices.
    always_comb begin
        out = '0;
        for (int i = 0; i < N; i++) begin
            out = out | (in[i*DATA_W_P +: DATA_W_P] & {DATA_W_P{sel[i]}});
        end
    end

    // Select comes from a registered upstream decode.
    a_sel_onehot: assert property (
        @(posedge clk) valid |-> $onehot(sel)
    ) else $error("mux select not one-hot: %h", sel);

endmodule

/* verilog/shift_network.sv */
`timescale 1ns/1ps

module shift_network (
    input  logic                  clk,
    input  shift_pkg::shift_dec_t dec,
    input  logic                  dec_valid,
    output shift_pkg::shift_rsp_t rsp_next
);

    import shift_pkg::*;

    logic [DATA_W*DATA_W-1:0] lane_res;
    logic [DATA_W-1:0]        lane_carry;
    logic [DATA_W-1:0]        result;
    logic                     carry;
    logic                     fill;

    // Sign copy for ASR, zeros otherwise.
    assign fill = (dec.op == ASR) & dec.data[DATA_W-1];

    for (genvar d = 0; d < DATA_W; d++) begin : g_lane
        logic [DATA_W-1:0] shl_d;
        logic [DATA_W-1:0] shr_d;
        logic [DATA_W-1:0] rol_d;
        logic [DATA_W-1:0] ror_d;
        logic [DATA_W-1:0] res_d;
        logic              out_l_d;
        logic              out_r_d;
        logic              carry_d;

        if (d == 0) begin : g_pass
            // Zero distance passes data through with no carry.
            assign shl_d   = dec.data;
            assign shr_d   = dec.data;
            assign rol_d   = dec.data;
            assign ror_d   = dec.data;
            assign out_l_d = 1'b0;
            assign out_r_d = 1'b0;
        end else begin : g_fixed
            assign shl_d   = {dec.data[DATA_W-1-d:0], {d{1'b0}}};
            assign shr_d   = {{d{fill}}, dec.data[DATA_W-1:d]};
            assign rol_d   = {dec.data[DATA_W-1-d:0], dec.data[DATA_W-1:DATA_W-d]};
            assign ror_d   = {dec.data[d-1:0], dec.data[DATA_W-1:d]};
            // Last bit off each end, which is also the wrapped bit of a rotate.
            assign out_l_d = dec.data[DATA_W-d];
            assign out_r_d = dec.data[d-1];
        end

        always_comb begin
            case (dec.op)
                SHL: begin
                    res_d   = shl_d;
                    carry_d = out_l_d;
                end
                SHR, ASR: begin
                    res_d   = shr_d;
                    carry_d = out_r_d;
                end
                ROL: begin
                    res_d   = rol_d;
                    carry_d = out_l_d;
                end
                ROR: begin
                    res_d   = ror_d;
                    carry_d = out_r_d;
                end
                default: begin
                    res_d   = dec.data;
                    carry_d = 1'b0;
                end
            endcase
        end

        assign lane_res[d*DATA_W +: DATA_W] = res_d;
        assign lane_carry[d]                = carry_d;
    end

    onehot_mux #(
        .N        (DATA_W),
        .DATA_W_P (DATA_W)
    ) u_res_mux (
        .clk   (clk),
        .valid (dec_valid),
        .in    (lane_res),
        .sel   (dec.lane),
        .out   (result)
    );

    onehot_mux #(
        .N        (DATA_W),
        .DATA_W_P (1)
    ) u_carry_mux (
        .clk   (clk),
        .valid (dec_valid),
        .in    (lane_carry),
        .sel   (dec.lane),
        .out   (carry)
    );

    assign rsp_next = '{result: result, carry: carry, zero: ~|result};

    // Rotations only move bits around.
    a_rot_popcount: assert property (
        @(posedge clk) dec_valid && (dec.op inside {ROL, ROR})
            |-> $countones(rsp_next.result) == $countones(dec.data)
    ) else $error("rotate changed bit count: %h -> %h", dec.data, rsp_next.result);

endmodule

/* verilog/shift_unit.sv */
`timescale 1ns/1ps

module shift_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  shift_pkg::shift_req_t req,
    output logic                  rsp_valid,
    output shift_pkg::shift_rsp_t rsp
);

    import shift_pkg::*;

    logic [DATA_W-1:0] lane;
    shift_dec_t        dec_q;
    logic              dec_valid;
    shift_rsp_t        rsp_next;

    // Stage 1 decode.
    onehot_decoder u_onehot_decoder (
        .clk    (clk),
        .amount (req.amount),
        .lane   (lane)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            dec_q <= '{op: req.op, lane: lane, data: req.data};
        end
    end

    // Stage 2 shift network.
    shift_network u_shift_network (
        .clk       (clk),
        .dec       (dec_q),
        .dec_valid (dec_valid),
        .rsp_next  (rsp_next)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= dec_valid;
        end
    end

    // Holds last response while idle.
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            rsp <= rsp_next;
        end
    end

    // Every strobe comes back exactly LATENCY cycles later, and nothing else does.
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
            $past(rst_n) && $past(rst_n, LATENCY)
                |-> rsp_valid == $past(req_valid, LATENCY)
    ) else $error("rsp_valid does not follow req_valid by %0d cycles", LATENCY);

endmodule

/* verif/shift_unit_tb.sv */
`timescale 1ns/1ps

module shift_unit_tb;

    import shift_pkg::*;

    typedef struct packed {
        shift_req_t req;
        shift_rsp_t rsp;
    } vec_t;

    localparam int TABLE_N    = 21;
    localparam int SWEEP_N    = 3 * 5 * 8;
    localparam int ROUND_N    = 2 * 8 * 2;
    localparam int RAND_N     = 200;
    localparam int TOTAL_N    = TABLE_N + SWEEP_N + ROUND_N + RAND_N;
    localparam int TIMEOUT_NS = (TOTAL_N + 20) * 10 * 4;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    shift_req_t req;
    logic       rsp_valid;
    shift_rsp_t rsp;

    vec_t        vec_q[$];
    shift_rsp_t  exp_q[$];
    shift_rsp_t  last_rsp;
    logic        have_last = 1'b0;
    logic [1:0]  pend = 2'b00;
    logic [31:0] lfsr_state = 32'd67850;
    int          errors = 0;
    int          sent_n = 0;
    int          got_n = 0;

    shift_unit u_shift_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1.
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Expected response from the operation rules.
    function automatic shift_rsp_t ref_shift(input shift_op_e op, input logic [2:0] n,
                                             input logic [7:0] d);
        logic [7:0] r;
        logic       c;
        int         k;
        k = int'(n);
        case (op)
            SHL: begin
                r = d << k;
                c = (k == 0) ? 1'b0 : d[3'(8 - k)];
            end
            SHR: begin
                r = d >> k;
                c = (k == 0) ? 1'b0 : d[3'(k - 1)];
            end
            ASR: begin
                r = (d >> k) | (d[7] ? ~(8'hFF >> k) : 8'h00);
                c = (k == 0) ? 1'b0 : d[3'(k - 1)];
            end
            ROL: begin
                r = (d << k) | (d >> (8 - k));
                c = (k == 0) ? 1'b0 : r[0];
            end
            ROR: begin
                r = (d >> k) | (d << (8 - k));
                c = (k == 0) ? 1'b0 : r[7];
            end
            default: begin
                r = d;
                c = 1'b0;
            end
        endcase
        return '{result: r, carry: c, zero: (r == 8'h00)};
    endfunction

    function automatic void add_vec(input shift_op_e opc, input logic [2:0] n,
                                    input logic [7:0] d, input logic [7:0] res,
                                    input logic c, input logic z);
        vec_t v;
        v.req = '{op: opc, amount: n, data: d};
        v.rsp = '{result: res, carry: c, zero: z};
        vec_q.push_back(v);
    endfunction

    task automatic send(input shift_req_t r, input shift_rsp_t e);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
        exp_q.push_back(e);
        sent_n++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        wait (exp_q.size() == 0);
    endtask

    task automatic run_sweep(input logic [7:0] d);
        shift_req_t r;
        for (int oi = 0; oi < 5; oi++) begin
            for (int n = 0; n < 8; n++) begin
                r = '{op: shift_op_e'(3'(oi)), amount: 3'(n), data: d};
                send(r, ref_shift(r.op, r.amount, r.data));
            end
            idle(1);
        end
    endtask

    // ROL then ROR by the same amount gives the data back.
    task automatic round_trip(input logic [7:0] d);
        shift_req_t r;
        shift_rsp_t rol_e;
        for (int n = 0; n < 8; n++) begin
            r = '{op: ROL, amount: 3'(n), data: d};
            rol_e = ref_shift(ROL, 3'(n), d);
            send(r, rol_e);
            drain();
            r = '{op: ROR, amount: 3'(n), data: rsp.result};
            send(r, ref_shift(ROR, 3'(n), rol_e.result));
            drain();
            check("restored data", 32'(rsp.result), 32'(d));
        end
    endtask

    // Outputs are sampled mid-cycle, away from the active edge.
    always @(negedge clk) begin
        shift_rsp_t e;
        if (rst_n) begin
            check("rsp_valid", 32'(rsp_valid), 32'(pend[1]));
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("A response arrived with no request outstanding at %0t", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check("rsp.result", 32'(rsp.result), 32'(e.result));
                    check("rsp.carry", 32'(rsp.carry), 32'(e.carry));
                    check("rsp.zero", 32'(rsp.zero), 32'(e.zero));
                end
                last_rsp  = rsp;
                have_last = 1'b1;
                got_n++;
            end else if (have_last) begin
                check("rsp held", 32'(rsp), 32'(last_rsp));
            end
            pend = {pend[0], req_valid};
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before all responses came back");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        shift_req_t r;
        logic [7:0] op_raw;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;

        add_vec(SHL, 3'd0, 8'hA5, 8'hA5, 1'b0, 1'b0);
        add_vec(SHL, 3'd1, 8'hA5, 8'h4A, 1'b1, 1'b0);
        add_vec(SHL, 3'd3, 8'hA5, 8'h28, 1'b1, 1'b0);
        add_vec(SHL, 3'd4, 8'hA5, 8'h50, 1'b0, 1'b0);
        add_vec(SHL, 3'd7, 8'hA5, 8'h80, 1'b0, 1'b0);
        add_vec(SHR, 3'd1, 8'hA5, 8'h52, 1'b1, 1'b0);
        add_vec(SHR, 3'd2, 8'hA5, 8'h29, 1'b0, 1'b0);
        add_vec(SHR, 3'd3, 8'hA5, 8'h14, 1'b1, 1'b0);
        add_vec(SHR, 3'd7, 8'hA5, 8'h01, 1'b0, 1'b0);
        add_vec(ASR, 3'd1, 8'h80, 8'hC0, 1'b0, 1'b0);
        add_vec(ASR, 3'd7, 8'h80, 8'hFF, 1'b0, 1'b0);
        add_vec(ASR, 3'd1, 8'h7F, 8'h3F, 1'b1, 1'b0);
        add_vec(ASR, 3'd6, 8'h7F, 8'h01, 1'b1, 1'b0);
        add_vec(ASR, 3'd7, 8'h7F, 8'h00, 1'b1, 1'b1);
        add_vec(ROL, 3'd1, 8'hA5, 8'h4B, 1'b1, 1'b0);
        add_vec(ROL, 3'd4, 8'hA5, 8'h5A, 1'b0, 1'b0);
        add_vec(ROL, 3'd7, 8'h01, 8'h80, 1'b0, 1'b0);
        add_vec(ROR, 3'd1, 8'hA5, 8'hD2, 1'b1, 1'b0);
        add_vec(ROR, 3'd3, 8'hA5, 8'hB4, 1'b1, 1'b0);
        add_vec(SHL, 3'd0, 8'h00, 8'h00, 1'b0, 1'b1);
        add_vec(SHR, 3'd1, 8'h01, 8'h00, 1'b1, 1'b1);

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        idle(3);

        // Table entries go out back to back.
        foreach (vec_q[i]) begin
            send(vec_q[i].req, vec_q[i].rsp);
        end
        drain();

        run_sweep(8'hA5);
        run_sweep(8'h80);
        run_sweep(8'h7F);
        drain();

        round_trip(8'hA5);
        round_trip(8'h7F);

        repeat (RAND_N) begin
            op_raw   = rand_bits(3);
            r.op     = shift_op_e'(3'(op_raw % 8'd5));
            r.amount = 3'(rand_bits(3));
            r.data   = rand_bits(8);
            send(r, ref_shift(r.op, r.amount, r.data));
            if (lfsr_bit()) begin
                idle(1);
            end
        end
        drain();
        idle(4);

        check("response count", 32'(got_n), 32'(sent_n));
        $display("Errors: %0d over %0d requests", errors, sent_n);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/shift_pkg.sv
verilog/onehot_decoder.sv
verilog/onehot_mux.sv
verilog/shift_network.sv
verilog/shift_unit.sv
verif/shift_unit_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := shift_unit_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir

BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
